/* spaceInvadersPkg.sv */
`default_nettype none

package spaceInvadersPkg;

    // Widths that carry a meaning across the design
    typedef logic [6:0] pixelX_t;
    typedef logic [5:0] pixelY_t;
    typedef logic [7:0] rgb_t;
    typedef logic [2:0] monsterIndex_t;
    typedef logic [7:0] aliveMask_t;

    // Raster frame sizes include the blanking area
    localparam pixelX_t FRAME_WIDTH    = 7'd80;
    localparam pixelY_t LINE_COUNT     = 6'd56;
    localparam pixelX_t VISIBLE_WIDTH  = 7'd64;
    localparam pixelY_t VISIBLE_HEIGHT = 6'd48;

    // Colours are RRRGGGBB
    localparam rgb_t BACKGROUND_RGB = 8'h01;
    localparam rgb_t BORDER_RGB     = 8'h92;
    localparam rgb_t PLAYER_RGB     = 8'h1C;
    localparam rgb_t MONSTER_RGB    = 8'hE0;

    // Player cannon
    localparam pixelY_t PLAYER_Y       = 6'd40;
    localparam pixelX_t PLAYER_WIDTH   = 7'd8;
    localparam pixelY_t PLAYER_HEIGHT  = 6'd4;
    localparam pixelX_t PLAYER_STEP    = 7'd2;
    localparam pixelX_t PLAYER_X_MAX   = 7'd56;
    localparam pixelX_t PLAYER_X_RESET = 7'd28;

    // Invaders are numbered row times four plus column
    localparam int MONSTER_COLUMNS = 4;
    localparam int MONSTER_ROWS    = 2;
    localparam int MONSTER_COUNT   = 8;

    localparam pixelX_t MONSTER_WIDTH   = 7'd6;
    localparam pixelY_t MONSTER_HEIGHT  = 6'd4;
    localparam pixelX_t MONSTER_PITCH_X = 7'd12;
    localparam pixelY_t MONSTER_PITCH_Y = 6'd8;

    // Grid origin at sweep offset 0
    localparam pixelX_t GRID_X0   = 7'd4;
    localparam pixelY_t GRID_Y0   = 6'd8;
    localparam pixelX_t SWEEP_MAX = 7'd12;

endpackage

`default_nettype wire

/* rasterIf.sv */
`timescale 1ns/1ps
`default_nettype none

interface rasterIf import spaceInvadersPkg::*; ();

    pixelX_t pixelX;
    pixelY_t pixelY;
    logic    visible;
    logic    startOfFrame;

    modport source (
        output pixelX,
        output pixelY,
        output visible,
        output startOfFrame
    );

    modport sink (
        input pixelX,
        input pixelY,
        input visible,
        input startOfFrame
    );

endinterface

`default_nettype wire

/* rasterScan.sv */
`timescale 1ns/1ps
`default_nettype none

module rasterScan import spaceInvadersPkg::*; (
    input  wire logic clk,
    input  wire logic reset,
    rasterIf.source   raster
);

    logic scanActive;
    logic lastPixel;
    logic lastLine;

    assign lastPixel = (raster.pixelX == pixelX_t'(FRAME_WIDTH - 1));
    assign lastLine  = (raster.pixelY == pixelY_t'(LINE_COUNT - 1));

    // The first cycle out of reset holds pixel (0,0) so that it is seen as a frame start
    always_ff @(posedge clk) begin
        if (reset) begin
            scanActive    <= 1'b0;
            raster.pixelX <= '0;
            raster.pixelY <= '0;
        end else begin
            scanActive <= 1'b1;
            if (scanActive) begin
                if (lastPixel) begin
                    raster.pixelX <= '0;
                    if (lastLine) begin
                        raster.pixelY <= '0;
                    end else begin
                        raster.pixelY <= raster.pixelY + 1'b1;
                    end
                end else begin
                    raster.pixelX <= raster.pixelX + 1'b1;
                end
            end
        end
    end

    assign raster.startOfFrame = scanActive && (raster.pixelX == '0) && (raster.pixelY == '0);

    assign raster.visible = (raster.pixelX < VISIBLE_WIDTH) && (raster.pixelY < VISIBLE_HEIGHT);

endmodule

`default_nettype wire

/* playerSprite.sv */
`timescale 1ns/1ps
`default_nettype none

module playerSprite import spaceInvadersPkg::*; (
    input  wire logic clk,
    input  wire logic reset,
    rasterIf.sink     raster,
    input  wire logic moveStrobe,
    input  wire logic moveRight,
    output logic      playerDraw,
    output rgb_t      playerRgb
);

    pixelX_t pendingX;
    pixelX_t displayX;
    logic    insideX;
    logic    insideY;

    // Moves collect in the pending position and show up at the next frame start
    always_ff @(posedge clk) begin
        if (reset) begin
            pendingX <= PLAYER_X_RESET;
        end else if (moveStrobe) begin
            if (moveRight) begin
                if (pendingX >= PLAYER_X_MAX - PLAYER_STEP) begin
                    pendingX <= PLAYER_X_MAX;
                end else begin
                    pendingX <= pendingX + PLAYER_STEP;
                end
            end else begin
                if (pendingX <= PLAYER_STEP) begin
                    pendingX <= '0;
                end else begin
                    pendingX <= pendingX - PLAYER_STEP;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            displayX <= PLAYER_X_RESET;
        end else if (raster.startOfFrame) begin
            displayX <= pendingX;
        end
    end

    assign insideX = (raster.pixelX >= displayX) && (raster.pixelX < displayX + PLAYER_WIDTH);
    assign insideY = (raster.pixelY >= PLAYER_Y) && (raster.pixelY < PLAYER_Y + PLAYER_HEIGHT);

    always_ff @(posedge clk) begin
        if (reset) begin
            playerDraw <= 1'b0;
            playerRgb  <= '0;
        end else begin
            playerDraw <= insideX && insideY;
            playerRgb  <= (insideX && insideY) ? PLAYER_RGB : rgb_t'(0);
        end
    end

endmodule

`default_nettype wire

/* monsterGrid.sv */
`timescale 1ns/1ps
`default_nettype none

module monsterGrid import spaceInvadersPkg::*; (
    input  wire logic           clk,
    input  wire logic           reset,
    rasterIf.sink               raster,
    input  wire logic           killStrobe,
    input  wire monsterIndex_t  killIndex,
    output logic                monsterDraw,
    output rgb_t                monsterRgb,
    output logic                allMonstersDead
);

    typedef enum logic {
        SWEEP_RIGHT,
        SWEEP_LEFT
    } sweepDir_t;

    aliveMask_t aliveMask;
    aliveMask_t displayMask;
    pixelX_t    sweepOffset;
    sweepDir_t  sweepDir;
    pixelX_t    cellX;
    pixelY_t    cellY;
    logic       cellHit;

    always_ff @(posedge clk) begin
        if (reset) begin
            aliveMask <= '1;
        end else if (killStrobe) begin
            aliveMask[killIndex] <= 1'b0;
        end
    end

    // Bits only ever clear, so this holds until reset
    assign allMonstersDead = (aliveMask == '0);

    // Display state is latched once per frame so a frame never changes halfway
    always_ff @(posedge clk) begin
        if (reset) begin
            displayMask <= '1;
            sweepOffset <= '0;
            sweepDir    <= SWEEP_RIGHT;
        end else if (raster.startOfFrame) begin
            displayMask <= aliveMask;
            if (sweepDir == SWEEP_RIGHT) begin
                sweepOffset <= sweepOffset + 1'b1;
                if (sweepOffset == SWEEP_MAX - 1'b1) begin
                    sweepDir <= SWEEP_LEFT;
                end
            end else begin
                sweepOffset <= sweepOffset - 1'b1;
                if (sweepOffset == pixelX_t'(1)) begin
                    sweepDir <= SWEEP_RIGHT;
                end
            end
        end
    end

    always_comb begin
        cellHit = 1'b0;
        cellX   = '0;
        cellY   = '0;
        for (int row = 0; row < MONSTER_ROWS; row++) begin
            for (int col = 0; col < MONSTER_COLUMNS; col++) begin
                cellX = GRID_X0 + sweepOffset + pixelX_t'(col * MONSTER_PITCH_X);
                cellY = GRID_Y0 + pixelY_t'(row * MONSTER_PITCH_Y);
                if (displayMask[row * MONSTER_COLUMNS + col]
                        && (raster.pixelX >= cellX)
                        && (raster.pixelX < cellX + MONSTER_WIDTH)
                        && (raster.pixelY >= cellY)
                        && (raster.pixelY < cellY + MONSTER_HEIGHT)) begin
                    cellHit = 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            monsterDraw <= 1'b0;
            monsterRgb  <= '0;
        end else begin
            monsterDraw <= cellHit;
            monsterRgb  <= cellHit ? MONSTER_RGB : rgb_t'(0);
        end
    end

endmodule

`default_nettype wire

/* objectMixer.sv */
`timescale 1ns/1ps
`default_nettype none

module objectMixer import spaceInvadersPkg::*; (
    input  wire logic    clk,
    input  wire logic    reset,
    rasterIf.sink        raster,
    input  wire logic    playerDraw,
    input  wire rgb_t    playerRgb,
    input  wire logic    monsterDraw,
    input  wire rgb_t    monsterRgb,
    output pixelX_t      videoX,
    output pixelY_t      videoY,
    output logic         videoVisible,
    output rgb_t         videoRgb
);

    pixelX_t pixelXD;
    pixelY_t pixelYD;
    logic    visibleD;
    logic    onBorder;
    rgb_t    mixedRgb;

    // Match the one cycle latency of the draw units
    always_ff @(posedge clk) begin
        pixelXD <= raster.pixelX;
        pixelYD <= raster.pixelY;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            visibleD <= 1'b0;
        end else begin
            visibleD <= raster.visible;
        end
    end

    assign onBorder = (pixelXD == '0) || (pixelXD == pixelX_t'(VISIBLE_WIDTH - 1))
                   || (pixelYD == '0) || (pixelYD == pixelY_t'(VISIBLE_HEIGHT - 1));

    // The player sits above the invaders and both sit above the border
    always_comb begin
        if (!visibleD) begin
            mixedRgb = '0;
        end else if (playerDraw) begin
            mixedRgb = playerRgb;
        end else if (monsterDraw) begin
            mixedRgb = monsterRgb;
        end else if (onBorder) begin
            mixedRgb = BORDER_RGB;
        end else begin
            mixedRgb = BACKGROUND_RGB;
        end
    end

    always_ff @(posedge clk) begin
        videoX <= pixelXD;
        videoY <= pixelYD;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            videoVisible <= 1'b0;
            videoRgb     <= '0;
        end else begin
            videoVisible <= visibleD;
            videoRgb     <= mixedRgb;
        end
    end

endmodule

`default_nettype wire

/* spaceInvadersVideo.sv */
`timescale 1ns/1ps
`default_nettype none

module spaceInvadersVideo import spaceInvadersPkg::*; (
    input  wire logic           clk,
    input  wire logic           reset,
    input  wire logic           moveStrobe,
    input  wire logic           moveRight,
    input  wire logic           killStrobe,
    input  wire monsterIndex_t  killIndex,
    output pixelX_t             videoX,
    output pixelY_t             videoY,
    output logic                videoVisible,
    output rgb_t                videoRgb,
    output logic                allMonstersDead
);

    logic playerDraw;
    rgb_t playerRgb;
    logic monsterDraw;
    rgb_t monsterRgb;

    rasterIf raster ();

    rasterScan rasterScanInst (
        .clk             (clk),
        .reset           (reset),
        .raster          (raster.source)
    );

    playerSprite playerSpriteInst (
        .clk             (clk),
        .reset           (reset),
        .raster          (raster.sink),
        .moveStrobe      (moveStrobe),
        .moveRight       (moveRight),
        .playerDraw      (playerDraw),
        .playerRgb       (playerRgb)
    );

    monsterGrid monsterGridInst (
        .clk             (clk),
        .reset           (reset),
        .raster          (raster.sink),
        .killStrobe      (killStrobe),
        .killIndex       (killIndex),
        .monsterDraw     (monsterDraw),
        .monsterRgb      (monsterRgb),
        .allMonstersDead (allMonstersDead)
    );

    objectMixer objectMixerInst (
        .clk             (clk),
        .reset           (reset),
        .raster          (raster.sink),
        .playerDraw      (playerDraw),
        .playerRgb       (playerRgb),
        .monsterDraw     (monsterDraw),
        .monsterRgb      (monsterRgb),
        .videoX          (videoX),
        .videoY          (videoY),
        .videoVisible    (videoVisible),
        .videoRgb        (videoRgb)
    );

endmodule

`default_nettype wire

/* tbSpaceInvaders.sv */
`timescale 1ns/1ps
`default_nettype none

module tbSpaceInvaders import spaceInvadersPkg::*; ();

    localparam int RANDOM_SEED  = 32'h440c6a6a;
    localparam int CLOCK_PERIOD = 100;
    localparam int RESET_CYCLES = 10;
    localparam int TOTAL_FRAMES = 16;
    localparam int FRAME_CYCLES = int'(FRAME_WIDTH) * int'(LINE_COUNT);
    localparam int CYCLE_LIMIT  = TOTAL_FRAMES * FRAME_CYCLES + 500;

    // Falling edges after reset is driven low. The raster shows (0,0) at the second one
    // and the output pipeline is two stages behind it
    localparam int FIRST_FRAME_EDGE = 4;

    // Commands go into the middle of the lower blanking lines
    localparam pixelY_t SLOT_FIRST_LINE = VISIBLE_HEIGHT + 6'd1;
    localparam pixelY_t SLOT_LAST_LINE  = LINE_COUNT - 6'd2;
    localparam pixelX_t SLOT_FIRST_X    = 7'd8;
    localparam pixelX_t SLOT_LAST_X     = 7'd63;

    logic          clk;
    logic          reset;
    logic          moveStrobe;
    logic          moveRight;
    logic          killStrobe;
    monsterIndex_t killIndex;
    pixelX_t       videoX;
    pixelY_t       videoY;
    logic          videoVisible;
    rgb_t          videoRgb;
    logic          allMonstersDead;

    // The stimulus owns the pending side of the model and the comparing process the shown side
    int         pendingX;
    aliveMask_t aliveModel;
    int         shownX;
    aliveMask_t shownMask;
    int         sweepOffset;
    logic       sweepRight;

    int         currentFrame;
    int         errorCount;
    int         checkCount;
    int         fallingEdges;
    logic       tracking;
    pixelX_t    expX;
    pixelY_t    expY;

    spaceInvadersVideo uut (
        .clk             (clk),
        .reset           (reset),
        .moveStrobe      (moveStrobe),
        .moveRight       (moveRight),
        .killStrobe      (killStrobe),
        .killIndex       (killIndex),
        .videoX          (videoX),
        .videoY          (videoY),
        .videoVisible    (videoVisible),
        .videoRgb        (videoRgb),
        .allMonstersDead (allMonstersDead)
    );

    initial begin
        clk = 1'b0;
        forever #(CLOCK_PERIOD / 2) clk = ~clk;
    end

    function automatic rgb_t expectedColour(input pixelX_t x, input pixelY_t y,
                                            input int cannonX, input aliveMask_t mask,
                                            input int offset);
        int   px;
        int   py;
        int   left;
        int   top;
        int   n;
        logic hitMonster;
        px = int'(x);
        py = int'(y);
        hitMonster = 1'b0;
        if (px >= int'(VISIBLE_WIDTH) || py >= int'(VISIBLE_HEIGHT)) begin
            return 8'h00;
        end
        if (px >= cannonX && px < cannonX + int'(PLAYER_WIDTH)
                && py >= int'(PLAYER_Y) && py < int'(PLAYER_Y) + int'(PLAYER_HEIGHT)) begin
            return PLAYER_RGB;
        end
        for (n = 0; n < MONSTER_COUNT; n++) begin
            left = int'(GRID_X0) + offset + (n % MONSTER_COLUMNS) * int'(MONSTER_PITCH_X);
            top  = int'(GRID_Y0) + (n / MONSTER_COLUMNS) * int'(MONSTER_PITCH_Y);
            if (mask[n] && px >= left && px < left + int'(MONSTER_WIDTH)
                    && py >= top && py < top + int'(MONSTER_HEIGHT)) begin
                hitMonster = 1'b1;
            end
        end
        if (hitMonster) begin
            return MONSTER_RGB;
        end
        if (px == 0 || px == int'(VISIBLE_WIDTH) - 1
                || py == 0 || py == int'(VISIBLE_HEIGHT) - 1) begin
            return BORDER_RGB;
        end
        return BACKGROUND_RGB;
    endfunction

    task automatic checkField(input string name, input logic [7:0] actual,
                              input logic [7:0] expected);
        checkCount++;
        assert (actual === expected) else begin
            errorCount++;
            $display("error: %s is %h, expected %h (frame %0d, x %0d, y %0d)",
                     name, actual, expected, currentFrame, expX, expY);
        end
    endtask

    // At a frame boundary the pending state becomes the shown state and the grid takes one step
    task automatic latchFrameState();
        currentFrame++;
        shownX    = pendingX;
        shownMask = aliveModel;
        if (sweepRight) begin
            sweepOffset++;
            if (sweepOffset == int'(SWEEP_MAX)) begin
                sweepRight = 1'b0;
            end
        end else begin
            sweepOffset--;
            if (sweepOffset == 0) begin
                sweepRight = 1'b1;
            end
        end
    endtask

    task automatic waitFrame(input int frame);
        while (currentFrame < frame) begin
            @(posedge clk);
        end
    endtask

    task automatic waitCommandSlot();
        @(posedge clk);
        while (!(videoY >= SLOT_FIRST_LINE && videoY <= SLOT_LAST_LINE
                && videoX >= SLOT_FIRST_X && videoX <= SLOT_LAST_X)) begin
            @(posedge clk);
        end
    endtask

    task automatic issueMove(input logic right);
        waitCommandSlot();
        moveStrobe <= 1'b1;
        moveRight  <= right;
        @(posedge clk);
        moveStrobe <= 1'b0;
        // The DUT took the strobe on this edge
        if (right) begin
            pendingX = pendingX + int'(PLAYER_STEP);
            if (pendingX > int'(PLAYER_X_MAX)) begin
                pendingX = int'(PLAYER_X_MAX);
            end
        end else begin
            pendingX = pendingX - int'(PLAYER_STEP);
            if (pendingX < 0) begin
                pendingX = 0;
            end
        end
    endtask

    task automatic issueKill(input int index);
        waitCommandSlot();
        killStrobe <= 1'b1;
        killIndex  <= monsterIndex_t'(index);
        @(posedge clk);
        killStrobe <= 1'b0;
        aliveModel[index] = 1'b0;
    endtask

    initial begin : compare
        rgb_t expRgb;
        logic expVisible;
        logic expDead;
        errorCount   = 0;
        checkCount   = 0;
        currentFrame = -1;
        fallingEdges = 0;
        tracking     = 1'b0;
        expX         = '0;
        expY         = '0;
        shownX       = int'(PLAYER_X_RESET);
        shownMask    = '1;
        sweepOffset  = 0;
        sweepRight   = 1'b1;
        forever begin
            @(negedge clk);
            if (reset) begin
                checkField("videoVisible", {7'b0, videoVisible}, 8'h00);
                checkField("videoRgb", videoRgb, 8'h00);
            end else begin
                fallingEdges++;
                if (fallingEdges == FIRST_FRAME_EDGE) begin
                    tracking = 1'b1;
                end
                if (tracking) begin
                    if (expX == '0 && expY == '0) begin
                        latchFrameState();
                    end
                    expVisible = (expX < VISIBLE_WIDTH) && (expY < VISIBLE_HEIGHT);
                    expRgb = expectedColour(expX, expY, shownX, shownMask, sweepOffset);
                    checkField("videoX", {1'b0, videoX}, {1'b0, expX});
                    checkField("videoY", {2'b0, videoY}, {2'b0, expY});
                    checkField("videoVisible", {7'b0, videoVisible}, {7'b0, expVisible});
                    checkField("videoRgb", videoRgb, expRgb);
                    if (expX == FRAME_WIDTH - 7'd1) begin
                        expX = '0;
                        if (expY == LINE_COUNT - 6'd1) begin
                            expY = '0;
                        end else begin
                            expY = expY + 6'd1;
                        end
                    end else begin
                        expX = expX + 7'd1;
                    end
                end
            end
            expDead = (aliveModel == '0);
            checkField("allMonstersDead", {7'b0, allMonstersDead}, {7'b0, expDead});
        end
    end

    initial begin : stimulus
        int count;
        int index;
        int frame;
        int lastAlive;
        reset      = 1'b1;
        moveStrobe = 1'b0;
        moveRight  = 1'b0;
        killStrobe = 1'b0;
        killIndex  = '0;
        pendingX   = int'(PLAYER_X_RESET);
        aliveModel = '1;
        void'($urandom(RANDOM_SEED));
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;

        // Frames 0 to 2 run untouched, then the cannon is pushed into both limits
        waitFrame(3);
        repeat (20) issueMove(1'b1);
        waitFrame(4);
        repeat (40) issueMove(1'b0);
        for (frame = 5; frame < 8; frame++) begin
            waitFrame(frame);
            count = 1 + int'($urandom % 12);
            repeat (count) issueMove(($urandom & 1) != 0);
        end

        waitFrame(8);
        index = 0;
        repeat (3) begin
            index = int'($urandom % MONSTER_COUNT);
            issueKill(index);
        end
        waitFrame(9);
        // Kill the same invader again while it is already dead
        issueKill(index);
        repeat (2) issueKill(int'($urandom % MONSTER_COUNT));

        // Leave only the highest numbered live invader for a later frame
        waitFrame(10);
        lastAlive = 0;
        for (index = 0; index < MONSTER_COUNT; index++) begin
            if (aliveModel[index]) begin
                lastAlive = index;
            end
        end
        for (index = 0; index < lastAlive; index++) begin
            if (aliveModel[index]) begin
                issueKill(index);
            end
        end
        waitFrame(12);
        issueKill(lastAlive);

        waitFrame(TOTAL_FRAMES);
        $display("Checks: %0d, errors: %0d", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    initial begin : watchdog
        int cycles;
        cycles = 0;
        while (cycles < CYCLE_LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout: the run did not reach its last frame within %0d cycles", CYCLE_LIMIT);
        $display("Checks: %0d, errors: %0d", checkCount, errorCount);
        $display("Simulation failed");
        $finish;
    end

endmodule

`default_nettype wire

/* files.f */
spaceInvadersPkg.sv
rasterIf.sv
rasterScan.sv
playerSprite.sv
monsterGrid.sv
objectMixer.sv
spaceInvadersVideo.sv
tbSpaceInvaders.sv

/* Makefile */
TOOL     := verilator
FLAGS    := --binary --timing --assert --timescale 1ns/1ps
TOP      := tbSpaceInvaders
FILELIST := files.f
OBJDIR   := obj_dir
BIN      := $(OBJDIR)/V$(TOP)
LOG      := sim.log
SOURCES  := $(shell cat $(FILELIST))

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -qx "Simulation passed" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)
